//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = regfile_subsystem_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim.f
source/regfile_types_pkg.sv
source/commit_types_pkg.sv
source/commit_queue.sv
source/commit_arbiter.sv
source/phys_register_file.sv
source/regfile_subsystem.sv
tests/commit_arbiter_props.sv
tests/regfile_subsystem_tb.sv

//--- source/commit_arbiter.sv
module commit_arbiter
    import regfile_types_pkg::*, commit_types_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic [num_producers-1:0]    head_valid,
    input  commit_entry_t               head_entry [num_producers],
    output logic [num_producers-1:0]    pop,
    output logic [num_commit_lanes-1:0] commit_enable,
    output phys_addr_t                  commit_addr [num_commit_lanes],
    output data_word_t                  commit_data [num_commit_lanes]
);

    // Producer scanned first in the current cycle
    producer_idx_t rr_ptr;
    producer_idx_t rr_next;

    // ============================================================
    // Lane selection
    // ============================================================

    // Walk the producers from rr_ptr and fill lanes 0, 1, 2 in that order.
    // A head whose register is already granted this cycle waits.
    always_comb begin
        logic [1:0]    lane;
        producer_idx_t idx;
        logic          conflict;

        pop = '0;
        commit_enable = '0;
        for (int l = 0; l < num_commit_lanes; l++) begin
            commit_addr[l] = '0;
            commit_data[l] = '0;
        end
        rr_next = rr_ptr;
        lane = '0;

        for (int i = 0; i < num_producers; i++) begin
            idx = rr_ptr + producer_idx_t'(i);

            // Same register on an earlier lane
            conflict = 1'b0;
            for (int l = 0; l < num_commit_lanes; l++) begin
                if (commit_enable[l] && commit_addr[l] == head_entry[idx].addr) begin
                    conflict = 1'b1;
                end
            end

            if (head_valid[idx] && !conflict && lane < 2'(num_commit_lanes)) begin
                pop[idx] = 1'b1;
                commit_enable[lane] = 1'b1;
                commit_addr[lane] = head_entry[idx].addr;
                commit_data[lane] = head_entry[idx].data;
                lane = lane + 1'b1;
                // Next cycle starts after the last producer served
                rr_next = idx + 2'd1;
            end
        end
    end

    // ============================================================
    // Round-robin pointer
    // ============================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rr_ptr <= '0;
        end else begin
            rr_ptr <= rr_next;
        end
    end

endmodule

//--- source/commit_queue.sv
module commit_queue
    import commit_types_pkg::*;
#(
    parameter int queue_depth = default_queue_depth
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          push,
    input  commit_entry_t push_entry,
    input  logic          pop,
    output commit_entry_t head_entry,
    output logic          head_valid,
    output logic          full
);

    localparam int ptr_width = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int count_width = $clog2(queue_depth + 1);

    commit_entry_t          entries [queue_depth];
    logic [ptr_width-1:0]   read_ptr;
    logic [ptr_width-1:0]   write_ptr;
    logic [count_width-1:0] count;
    logic                   push_accept;
    logic                   pop_accept;

    // Wrap also works for depths that are not a power of two
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(queue_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Flags come straight from the registered count
    assign full = (count == count_width'(queue_depth));
    assign head_valid = (count != '0);
    assign head_entry = entries[read_ptr];

    // A push while full is dropped, the producer holds it
    assign push_accept = push && !full;
    assign pop_accept = pop && head_valid;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            read_ptr <= '0;
            write_ptr <= '0;
            count <= '0;
        end else begin
            if (push_accept) begin
                write_ptr <= next_ptr(write_ptr);
            end
            if (pop_accept) begin
                read_ptr <= next_ptr(read_ptr);
            end
            case ({push_accept, pop_accept})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push_accept) begin
            entries[write_ptr] <= push_entry;
        end
    end

endmodule

//--- source/commit_types_pkg.sv
package commit_types_pkg;

    import regfile_types_pkg::*;

    // ============================================================
    // Commit traffic between producers and the register file
    // ============================================================

    // Four retire producers, three commit lanes into the register file
    localparam int num_producers = 4;
    localparam int num_commit_lanes = 3;

    // Entries per commit queue unless the top level overrides it
    localparam int default_queue_depth = 4;

    // Round-robin pointer over the producers
    typedef logic [1:0] producer_idx_t;

    // One committed result, 38 bits
    typedef struct packed {
        phys_addr_t addr;
        data_word_t data;
    } commit_entry_t;

endpackage

//--- source/phys_register_file.sv
module phys_register_file
    import regfile_types_pkg::*;
#(
    parameter int data_width = $bits(data_word_t),
    parameter int addr_width = $bits(phys_addr_t),
    parameter int num_registers = regfile_types_pkg::num_registers
) (
    input  logic       clk,
    input  logic       reset,

    // Commit lanes, lane 2 is the youngest
    input  logic       commit_enable_0,
    input  logic       commit_enable_1,
    input  logic       commit_enable_2,
    input  phys_addr_t commit_addr_0,
    input  phys_addr_t commit_addr_1,
    input  phys_addr_t commit_addr_2,
    input  data_word_t commit_data_0,
    input  data_word_t commit_data_1,
    input  data_word_t commit_data_2,

    // Operand reads for three instructions
    input  phys_addr_t inst_0_read_addr_a,
    input  phys_addr_t inst_0_read_addr_b,
    input  phys_addr_t inst_1_read_addr_a,
    input  phys_addr_t inst_1_read_addr_b,
    input  phys_addr_t inst_2_read_addr_a,
    input  phys_addr_t inst_2_read_addr_b,
    output data_word_t inst_0_read_data_a,
    output data_word_t inst_0_read_data_b,
    output data_word_t inst_1_read_data_a,
    output data_word_t inst_1_read_data_b,
    output data_word_t inst_2_read_data_a,
    output data_word_t inst_2_read_data_b
);

    logic [data_width-1:0] register_data [num_registers];

    // ============================================================
    // Commit writes
    // ============================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < num_registers; i++) begin
                register_data[i] <= '0;
            end
            register_data[sp_register] <= sp_reset_value;
        end else begin
            if (commit_enable_0 && commit_addr_0 != '0) begin
                register_data[commit_addr_0] <= commit_data_0;
            end
            if (commit_enable_1 && commit_addr_1 != '0) begin
                register_data[commit_addr_1] <= commit_data_1;
            end
            if (commit_enable_2 && commit_addr_2 != '0) begin
                register_data[commit_addr_2] <= commit_data_2;
            end
            // x0 stays zero whatever was committed
            register_data[0] <= '0;
        end
    end

    // ============================================================
    // Reads with same-cycle forwarding
    // ============================================================

    // Lanes are applied oldest first so lane 2 ends up on top.
    // Register 0 never forwards and its storage is always zero.
    function automatic logic [data_width-1:0] read_port(
        input logic [addr_width-1:0] addr
    );
        logic [data_width-1:0] value;
        logic                  forwardable;

        value = register_data[addr];
        forwardable = (addr != '0);
        if (forwardable && commit_enable_0 && commit_addr_0 == addr) begin
            value = commit_data_0;
        end
        if (forwardable && commit_enable_1 && commit_addr_1 == addr) begin
            value = commit_data_1;
        end
        if (forwardable && commit_enable_2 && commit_addr_2 == addr) begin
            value = commit_data_2;
        end
        return value;
    endfunction

    // Instruction 0 operands
    always_comb begin
        inst_0_read_data_a = read_port(inst_0_read_addr_a);
        inst_0_read_data_b = read_port(inst_0_read_addr_b);
    end

    // Instruction 1 operands
    always_comb begin
        inst_1_read_data_a = read_port(inst_1_read_addr_a);
        inst_1_read_data_b = read_port(inst_1_read_addr_b);
    end

    // Instruction 2 operands
    always_comb begin
        inst_2_read_data_a = read_port(inst_2_read_addr_a);
        inst_2_read_data_b = read_port(inst_2_read_addr_b);
    end

endmodule

//--- source/regfile_subsystem.sv
module regfile_subsystem
    import regfile_types_pkg::*, commit_types_pkg::*;
#(
    parameter int queue_depth = default_queue_depth
) (
    input  logic                     clk,
    input  logic                     reset,

    // Producer side
    input  logic [num_producers-1:0] push_valid,
    input  phys_addr_t               push_addr [num_producers],
    input  data_word_t               push_data [num_producers],
    output logic [num_producers-1:0] full,

    // Read ports, a and b of instruction 0, then 1, then 2
    input  phys_addr_t               read_addr [num_read_ports],
    output data_word_t               read_data [num_read_ports],

    output logic                     idle
);

    commit_entry_t                 push_entry [num_producers];
    commit_entry_t                 head_entry [num_producers];
    logic [num_producers-1:0]      head_valid;
    logic [num_producers-1:0]      pop;
    logic [num_commit_lanes-1:0]   commit_enable;
    phys_addr_t                    commit_addr [num_commit_lanes];
    data_word_t                    commit_data [num_commit_lanes];

    // ============================================================
    // Commit queues, one per producer
    // ============================================================

    for (genvar p = 0; p < num_producers; p++) begin : g_queue
        assign push_entry[p] = '{addr: push_addr[p], data: push_data[p]};

        commit_queue #(
            .queue_depth(queue_depth)
        ) i_commit_queue (
            .clk(clk),
            .reset(reset),
            .push(push_valid[p]),
            .push_entry(push_entry[p]),
            .pop(pop[p]),
            .head_entry(head_entry[p]),
            .head_valid(head_valid[p]),
            .full(full[p])
        );
    end

    // Every accepted push has reached the register file
    assign idle = &(~head_valid);

    // ============================================================
    // Arbitration and storage
    // ============================================================

    commit_arbiter i_commit_arbiter (
        .clk(clk),
        .reset(reset),
        .head_valid(head_valid),
        .head_entry(head_entry),
        .pop(pop),
        .commit_enable(commit_enable),
        .commit_addr(commit_addr),
        .commit_data(commit_data)
    );

    phys_register_file #(
        .data_width($bits(data_word_t)),
        .addr_width($bits(phys_addr_t)),
        .num_registers(num_registers)
    ) i_phys_register_file (
        .clk(clk),
        .reset(reset),
        .commit_enable_0(commit_enable[0]),
        .commit_enable_1(commit_enable[1]),
        .commit_enable_2(commit_enable[2]),
        .commit_addr_0(commit_addr[0]),
        .commit_addr_1(commit_addr[1]),
        .commit_addr_2(commit_addr[2]),
        .commit_data_0(commit_data[0]),
        .commit_data_1(commit_data[1]),
        .commit_data_2(commit_data[2]),
        .inst_0_read_addr_a(read_addr[0]),
        .inst_0_read_addr_b(read_addr[1]),
        .inst_1_read_addr_a(read_addr[2]),
        .inst_1_read_addr_b(read_addr[3]),
        .inst_2_read_addr_a(read_addr[4]),
        .inst_2_read_addr_b(read_addr[5]),
        .inst_0_read_data_a(read_data[0]),
        .inst_0_read_data_b(read_data[1]),
        .inst_1_read_data_a(read_data[2]),
        .inst_1_read_data_b(read_data[3]),
        .inst_2_read_data_a(read_data[4]),
        .inst_2_read_data_b(read_data[5])
    );

endmodule

//--- source/regfile_types_pkg.sv
package regfile_types_pkg;

    // ============================================================
    // Architectural data and physical register addressing
    // ============================================================

    localparam int data_width = 32;
    localparam int addr_width = 6;

    // 64 physical registers behind a 6-bit index
    localparam int num_registers = 64;

    // Operands a and b for three instructions
    localparam int num_read_ports = 6;

    typedef logic [data_width-1:0] data_word_t;
    typedef logic [addr_width-1:0] phys_addr_t;

    // ============================================================
    // Reset contents
    // ============================================================

    // Stack pointer register starts at the top of the stack
    localparam int sp_register = 2;
    localparam data_word_t sp_reset_value = 32'h7FFF_FFF0;

endpackage

//--- tests/commit_arbiter_props.sv
module commit_arbiter_props
    import regfile_types_pkg::*, commit_types_pkg::*;
(
    input logic                        clk,
    input logic                        reset,
    input logic [num_producers-1:0]    head_valid,
    input logic [num_producers-1:0]    pop,
    input logic [num_commit_lanes-1:0] commit_enable,
    input phys_addr_t                  commit_addr [num_commit_lanes]
);
    timeunit 1ns;
    timeprecision 100ps;

    int   failure_count = 0;
    logic lanes_distinct;

    // No two enabled lanes target one register
    always_comb begin
        lanes_distinct = 1'b1;
        for (int i = 0; i < num_commit_lanes; i++) begin
            for (int j = i + 1; j < num_commit_lanes; j++) begin
                if (commit_enable[i] && commit_enable[j] && commit_addr[i] == commit_addr[j]) begin
                    lanes_distinct = 1'b0;
                end
            end
        end
    end

    lane_addresses_unique: assert property (@(posedge clk) disable iff (!reset) lanes_distinct)
        else begin
            $error("two enabled commit lanes carry the same register address");
            failure_count++;
        end

    pop_needs_head: assert property (@(posedge clk) disable iff (!reset) (pop & ~head_valid) == '0)
        else begin
            $error("pop raised for a queue with no valid head");
            failure_count++;
        end

    lanes_match_pops: assert property (@(posedge clk) disable iff (!reset)
                                       $countones(commit_enable) == $countones(pop))
        else begin
            $error("enabled commit lanes differ from the number of pops");
            failure_count++;
        end

endmodule

bind commit_arbiter commit_arbiter_props i_commit_arbiter_props (
    .clk(clk),
    .reset(reset),
    .head_valid(head_valid),
    .pop(pop),
    .commit_enable(commit_enable),
    .commit_addr(commit_addr)
);

//--- tests/regfile_subsystem_tb.sv
module regfile_subsystem_tb
    import regfile_types_pkg::*, commit_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clock_period = 100;
    localparam int timeout_cycles = 3000;
    localparam int max_stream = 48;

    logic                     clk;
    logic                     reset;
    logic [num_producers-1:0] push_valid;
    phys_addr_t               push_addr [num_producers];
    data_word_t               push_data [num_producers];
    logic [num_producers-1:0] full;
    phys_addr_t               read_addr [num_read_ports];
    data_word_t               read_data [num_read_ports];
    logic                     idle;

    // Expected register contents, updated in push order per producer
    data_word_t model [num_registers];
    // Entries each producer pushes in the next stream
    phys_addr_t stream_addr [num_producers][max_stream];
    data_word_t stream_data [num_producers][max_stream];
    int         stream_len [num_producers];
    int         word_errors;
    int         flag_errors;
    int         other_errors;
    int         assert_errors;
    int         cycle_count;
    int         seed;
    logic       saw_full;

    regfile_subsystem #(
        .queue_depth(4)
    ) i_dut (
        .clk(clk),
        .reset(reset),
        .push_valid(push_valid),
        .push_addr(push_addr),
        .push_data(push_data),
        .full(full),
        .read_addr(read_addr),
        .read_data(read_data),
        .idle(idle)
    );

    initial begin
        clk = 1'b0;
        forever #(clock_period / 2) clk = ~clk;
    end

    // Ends the run if the tests stop making progress
    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", timeout_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    // ============================================================
    // Compare tasks and helpers
    // ============================================================

    task automatic check_word(input string name, input data_word_t actual,
                              input data_word_t expected);
        if (actual !== expected) begin
            $display("error %s got %h expected %h", name, actual, expected);
            word_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("error %s got %h expected %h", name, actual, expected);
            flag_errors++;
        end
    endtask

    function automatic int random_below(input int limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    task automatic add_entry(input int p, input int addr, input data_word_t data);
        stream_addr[p][stream_len[p]] = phys_addr_t'(addr);
        stream_data[p][stream_len[p]] = data;
        stream_len[p]++;
    endtask

    // Every producer pushes its stream, holding an entry while full is high
    task automatic drive_streams();
        int  idx [num_producers];
        logic done;

        foreach (idx[p]) idx[p] = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = 1'b1;
            for (int p = 0; p < num_producers; p++) begin
                push_valid[p] = (idx[p] < stream_len[p]);
                if (push_valid[p]) begin
                    done = 1'b0;
                    push_addr[p] = stream_addr[p][idx[p]];
                    push_data[p] = stream_data[p][idx[p]];
                    if (!full[p]) begin
                        if (push_addr[p] != '0) model[push_addr[p]] = push_data[p];
                        idx[p]++;
                    end
                end
            end
            if (full != '0) saw_full = 1'b1;
        end
        foreach (stream_len[p]) stream_len[p] = 0;
    endtask

    task automatic wait_idle();
        while (!idle) @(negedge clk);
    endtask

    // All six ports read one register
    task automatic check_register(input int r);
        @(negedge clk);
        foreach (read_addr[k]) read_addr[k] = phys_addr_t'(r);
        #10;
        foreach (read_data[k]) begin
            check_word($sformatf("read_data[%0d] register %0d", k, r), read_data[k], model[r]);
        end
    endtask

    task automatic check_all_registers();
        for (int r = 0; r < num_registers; r++) check_register(r);
    endtask

    // ============================================================
    // Directed tests
    // ============================================================

    task automatic test_reset();
        check_flag("idle", idle, 1'b1);
        for (int p = 0; p < num_producers; p++) begin
            check_flag($sformatf("full[%0d]", p), full[p], 1'b0);
        end
        check_all_registers();
    endtask

    task automatic test_write_read();
        add_entry(0, 5, 32'h1111_0005);
        add_entry(0, 6, 32'h2222_0006);
        add_entry(0, 0, 32'hDEAD_BEEF);
        add_entry(0, 63, 32'h3333_003F);
        drive_streams();
        wait_idle();
        check_all_registers();
    endtask

    // Port 0 stays on register 17 while one push goes through
    task automatic test_forwarding();
        data_word_t old_value;
        data_word_t new_value;
        logic       switched;

        old_value = model[17];
        new_value = 32'hF0F0_1717;
        switched = 1'b0;
        @(negedge clk);
        read_addr[0] = 6'd17;
        push_valid[1] = 1'b1;
        push_addr[1] = 6'd17;
        push_data[1] = new_value;
        #10;
        check_word("read_data[0] before commit", read_data[0], old_value);
        for (int c = 0; c < 6; c++) begin
            @(negedge clk);
            push_valid[1] = 1'b0;
            #10;
            if (c == 0) begin
                // Entry still queued in its grant cycle, so the new value is forwarded
                check_flag("idle in grant cycle", idle, 1'b0);
                check_word("read_data[0] in grant cycle", read_data[0], new_value);
            end
            if (read_data[0] === new_value) begin
                switched = 1'b1;
            end else if (switched || read_data[0] !== old_value) begin
                $display("Register 17 showed %h instead of old %h then new %h",
                         read_data[0], old_value, new_value);
                other_errors++;
            end
        end
        check_word("read_data[0] after commit", read_data[0], new_value);
        model[17] = new_value;
        wait_idle();
    endtask

    task automatic test_order();
        add_entry(0, 20, 32'hA000_0014);
        add_entry(1, 21, 32'hA100_0015);
        add_entry(2, 9, 32'hA200_0009);
        add_entry(2, 9, 32'hA2FF_0009);
        add_entry(3, 23, 32'hA300_0017);
        drive_streams();
        wait_idle();
        check_all_registers();
    endtask

    task automatic test_back_pressure();
        for (int p = 0; p < num_producers; p++) begin
            for (int i = 0; i < 40; i++) begin
                add_entry(p, 1 + p * 15 + i % 15, 32'hB000_0000 | (32'(p) << 16) | 32'(i));
            end
        end
        saw_full = 1'b0;
        drive_streams();
        wait_idle();
        check_flag("full seen", saw_full, 1'b1);
        check_all_registers();
    endtask

    task automatic test_random_traffic();
        int count;

        for (int round = 0; round < 4; round++) begin
            for (int p = 0; p < num_producers; p++) begin
                count = 1 + random_below(12);
                for (int i = 0; i < count; i++) begin
                    add_entry(p, 1 + p * 15 + random_below(15), $random(seed));
                end
            end
            drive_streams();
            wait_idle();
            repeat (8) begin
                @(negedge clk);
                foreach (read_addr[k]) read_addr[k] = phys_addr_t'(random_below(num_registers));
                #10;
                foreach (read_data[k]) begin
                    check_word($sformatf("read_data[%0d] register %0d", k, read_addr[k]),
                               read_data[k], model[read_addr[k]]);
                end
            end
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        seed = 35184;
        word_errors = 0;
        flag_errors = 0;
        other_errors = 0;
        reset = 1'b0;
        push_valid = '0;
        foreach (push_addr[p]) push_addr[p] = '0;
        foreach (push_data[p]) push_data[p] = '0;
        foreach (read_addr[k]) read_addr[k] = '0;
        foreach (stream_len[p]) stream_len[p] = 0;
        foreach (model[r]) model[r] = '0;
        // Stack pointer register
        model[2] = 32'h7FFF_FFF0;
        repeat (4) @(negedge clk);
        reset = 1'b1;

        test_reset();
        test_write_read();
        test_forwarding();
        test_order();
        test_back_pressure();
        test_random_traffic();

        assert_errors = i_dut.i_commit_arbiter.i_commit_arbiter_props.failure_count;
        $display("Errors: %0d word, %0d flag, %0d other, %0d assertion",
                 word_errors, flag_errors, other_errors, assert_errors);
        if (word_errors + flag_errors + other_errors + assert_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
